/* hdl/drbg_consts.svh */
// Shared constants for the DRBG and its mixing core
// All data paths are one word wide, K, V, tag and output alike
// The mixer constants are for sequencing tests only, not for security

`ifndef DRBG_CONSTS_SVH
`define DRBG_CONSTS_SVH

//------------------------------------------------------------
// Word width and DRBG seed values
//------------------------------------------------------------
`define DRBG_W       64

`define DRBG_K_INIT  64'h0000_0000_0000_0000  // K starts as all zero bytes
`define DRBG_V_INIT  64'h0101_0101_0101_0101  // V starts as all 0x01 bytes

// Upper bound q, accepted range is [1, q-1]
`define DRBG_LIMIT   64'hF000_0000_0000_0000

//------------------------------------------------------------
// Mixing core
//------------------------------------------------------------
`define MIX_ROUNDS   8                       // Rounds per absorbed block
`define MIX_ROT      13                      // Rotate left per round
`define MIX_RC       64'h9E37_79B9_7F4A_7C15 // Round r uses MIX_RC + r

`endif

/* hdl/drbg_pkg.sv */
// Types shared by the DRBG controller and the mixing core
// Widths come from the constants header

`default_nettype none

`include "drbg_consts.svh"

package drbg_pkg;

  typedef logic [`DRBG_W-1:0] drbg_word_t;  // Key, message, tag, output
  typedef logic [7:0]         drbg_cnt_t;   // Generation counter

  // One request to the mixing core
  typedef struct packed {
    logic       start;   // Strobe, new tag seeded from key
    logic       absorb;  // Strobe, chain on previous tag
    drbg_word_t key;
    drbg_word_t block;
  } mix_cmd_t;

  // Status and result from the mixing core
  typedef struct packed {
    logic       idle;       // Level, ready for a command
    logic       tag_valid;  // Level, tag holds a finished result
    drbg_word_t tag;
  } mix_rsp_t;

  // Controller states
  typedef enum logic [3:0] {
    IDLE,
    INIT,     // Load K, V initial values
    NEXT,     // Bump counter for a new request
    K1,       // K = mix(V || cnt,0x00 || entropy || nonce)
    V1,       // V = mix(V)
    K2_PREP,  // Bump counter
    K2,       // K = mix(V || cnt,0x01 || entropy || nonce)
    V2,       // V = mix(V)
    T,        // T = mix(V), V takes T
    CHECK,    // Range check on T
    K3,       // Reject path, K = mix(V || 0)
    V3,       // Reject path, V = mix(V)
    DONE
  } drbg_state_e;

endpackage

`default_nettype wire

/* hdl/keyed_mix_core.sv */
// Keyed mixing core, one 64-bit block per command, MIX_ROUNDS cycles each
// Commands are accepted only while idle, others are dropped
// Not a cryptographic function, only a stand-in for an HMAC core
// The key is latched on start and reused by absorb

`default_nettype none

`include "drbg_consts.svh"

module keyed_mix_core import drbg_pkg::*; (
  input  wire           clk,
  input  wire           reset_n,
  input  wire           zeroize,   // Sync clear to idle, no tag
  input  wire mix_cmd_t cmd,
  output mix_rsp_t      rsp
);

  localparam int RCW = $clog2(`MIX_ROUNDS);

  //------------------------------------------------------------
  // Registers
  //------------------------------------------------------------
  drbg_word_t     state_q;    // Working state, holds tag when done
  drbg_word_t     key_q;      // Key for current tag chain
  logic [RCW-1:0] round_q;
  logic           busy_q;
  logic           tag_valid_q;

  drbg_word_t     base;       // Start value before block XOR
  logic           cmd_go;

  // One round: add key, rotate left, XOR round constant
  function automatic drbg_word_t mix_round(input drbg_word_t s,
                                           input drbg_word_t k,
                                           input logic [RCW-1:0] r);
    drbg_word_t sum;
    drbg_word_t rot;
    sum = s + k;
    rot = (sum << `MIX_ROT) | (sum >> (`DRBG_W - `MIX_ROT));
    return rot ^ (`MIX_RC + drbg_word_t'(r));
  endfunction

  assign cmd_go = ~busy_q & (cmd.start | cmd.absorb);  // Ignored while busy
  assign base   = cmd.start ? cmd.key : state_q;        // Absorb chains on last tag

  //------------------------------------------------------------
  // Control, round counter and done flag
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q      <= 1'b0;
      tag_valid_q <= 1'b0;
      round_q     <= '0;
    end else if (zeroize) begin
      busy_q      <= 1'b0;
      tag_valid_q <= 1'b0;
      round_q     <= '0;
    end else if (cmd_go) begin
      busy_q      <= 1'b1;          // Idle and valid drop on this edge
      tag_valid_q <= 1'b0;
      round_q     <= '0;
    end else if (busy_q) begin
      round_q <= round_q + 1'b1;
      if (round_q == RCW'(`MIX_ROUNDS - 1)) begin
        busy_q      <= 1'b0;        // Last round, tag ready
        tag_valid_q <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= '0;
      key_q   <= '0;
    end else if (zeroize) begin
      state_q <= '0;                // Wipe key material too
      key_q   <= '0;
    end else if (cmd_go) begin
      state_q <= base ^ cmd.block;
      if (cmd.start)
        key_q <= cmd.key;
    end else if (busy_q) begin
      state_q <= mix_round(state_q, key_q, round_q);
    end
  end

  // Tag is the final state, held until the next command
  assign rsp.idle      = ~busy_q;
  assign rsp.tag_valid = tag_valid_q;
  assign rsp.tag       = state_q;

endmodule

`default_nettype wire

/* hdl/drbg_ctrl.sv */
// HMAC-DRBG style controller, K and V update then generate with range check
// One output per init or next command, latency depends on rejections
// Commands are one-cycle strobes, taken only when ready is high and exactly
// one of init_cmd and next_cmd is set; entropy and nonce are sampled then
// Output stays until the next accepted command

`default_nettype none

`include "drbg_consts.svh"

module drbg_ctrl import drbg_pkg::*; (
  input  wire             clk,
  input  wire             reset_n,
  input  wire             zeroize,
  input  wire             init_cmd,
  input  wire             next_cmd,
  input  wire drbg_word_t entropy,
  input  wire drbg_word_t nonce,
  output mix_cmd_t        mix_cmd,
  input  wire mix_rsp_t   mix_rsp,
  output logic            ready,
  output logic            valid,
  output drbg_word_t      drbg
);

  //------------------------------------------------------------
  // Registers and decode
  //------------------------------------------------------------
  drbg_state_e st_q;
  drbg_state_e st_d;
  drbg_state_e st_last_q;    // Previous state, for first-cycle detect

  drbg_word_t  k_q;
  drbg_word_t  v_q;          // Also holds T after the T step
  drbg_word_t  ent_q;        // Sampled entropy
  drbg_word_t  non_q;        // Sampled nonce
  drbg_word_t  drbg_q;
  drbg_cnt_t   cnt_q;
  logic [1:0]  blk_idx_q;    // Block within a multi-block message

  logic        start_q;
  logic        absorb_q;
  logic        ready_q;
  logic        valid_q;
  logic        tv_last_q;    // Registered tag_valid

  drbg_word_t  blk_word;
  logic [7:0]  marker;
  logic        first;
  logic        tag_edge;
  logic        last_blk;
  logic        accept;
  logic        t_ok;

  // States that run the mixer
  function automatic logic is_mix_state(input drbg_state_e s);
    return (s == K1) || (s == V1) || (s == K2) || (s == V2) ||
           (s == T)  || (s == K3) || (s == V3);
  endfunction

  assign first    = (st_q != st_last_q);
  assign tag_edge = mix_rsp.tag_valid & ~tv_last_q;   // Tag just finished
  assign accept   = (st_q == IDLE) & ready_q & mix_rsp.idle & (init_cmd ^ next_cmd);
  assign t_ok     = (v_q != '0) && (v_q < `DRBG_LIMIT);
  assign marker   = (st_q == K2) ? 8'h01 : 8'h00;

  // Last block of the message in the current state
  always_comb begin
    unique case (st_q)
      K1, K2:  last_blk = (blk_idx_q == 2'd3);  // V, cnt, entropy, nonce
      K3:      last_blk = (blk_idx_q == 2'd1);  // V, zero word
      default: last_blk = 1'b1;                 // Single block
    endcase
  end

  // Block presented to the mixer
  always_comb begin
    unique case (st_q)
      K1, K2: begin
        unique case (blk_idx_q)
          2'd0:    blk_word = v_q;
          2'd1:    blk_word = {cnt_q, marker, {(`DRBG_W-16){1'b0}}};
          2'd2:    blk_word = ent_q;
          default: blk_word = non_q;
        endcase
      end
      K3:      blk_word = (blk_idx_q == 2'd0) ? v_q : '0;
      default: blk_word = v_q;
    endcase
  end

  //------------------------------------------------------------
  // Next state
  //------------------------------------------------------------
  always_comb begin
    st_d = st_q;
    unique case (st_q)
      IDLE:       if (accept) st_d = init_cmd ? INIT : NEXT;
      INIT, NEXT: st_d = K1;
      K1:         if (tag_edge && last_blk) st_d = V1;
      V1:         if (tag_edge) st_d = K2_PREP;
      K2_PREP:    st_d = K2;
      K2:         if (tag_edge && last_blk) st_d = V2;
      V2:         if (tag_edge) st_d = T;
      T:          if (tag_edge) st_d = CHECK;
      CHECK:      st_d = t_ok ? DONE : K3;    // Retry on out of range T
      K3:         if (tag_edge && last_blk) st_d = V3;
      V3:         if (tag_edge) st_d = T;
      DONE:       st_d = IDLE;
      default:    st_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      st_q      <= IDLE;
      st_last_q <= IDLE;
      tv_last_q <= 1'b0;
      ready_q   <= 1'b0;
    end else if (zeroize) begin
      st_q      <= IDLE;
      st_last_q <= IDLE;
      tv_last_q <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      st_q      <= st_d;
      st_last_q <= st_q;
      tv_last_q <= mix_rsp.tag_valid;
      ready_q   <= (st_d == IDLE);   // Low right after an accepted command
    end
  end

  //------------------------------------------------------------
  // Mixer command strobes, one per block
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_q   <= 1'b0;
      absorb_q  <= 1'b0;
      blk_idx_q <= '0;
    end else if (zeroize) begin
      start_q   <= 1'b0;
      absorb_q  <= 1'b0;
      blk_idx_q <= '0;
    end else begin
      start_q  <= first & is_mix_state(st_q);  // First block on state entry
      absorb_q <= 1'b0;
      if (st_d != st_q)
        blk_idx_q <= '0;
      else if (tag_edge && !last_blk) begin
        blk_idx_q <= blk_idx_q + 2'd1;         // Chain the next block
        absorb_q  <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------
  // K, V, counter and sampled inputs
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      k_q   <= '0;
      v_q   <= '0;
      cnt_q <= '0;
      ent_q <= '0;
      non_q <= '0;
    end else if (zeroize) begin
      k_q   <= '0;
      v_q   <= '0;
      cnt_q <= '0;
      ent_q <= '0;
      non_q <= '0;
    end else begin
      unique case (st_q)
        IDLE: if (accept) begin
          ent_q <= entropy;
          non_q <= nonce;
        end
        INIT: begin
          k_q   <= `DRBG_K_INIT;
          v_q   <= `DRBG_V_INIT;
          cnt_q <= '0;
        end
        NEXT, K2_PREP: cnt_q <= cnt_q + 8'd1;
        K1, K2, K3:    if (tag_edge && last_blk) k_q <= mix_rsp.tag;
        V1, V2, T, V3: if (tag_edge) v_q <= mix_rsp.tag;  // T lands in V
        default: ;
      endcase
    end
  end

  // Output register and valid level
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
      drbg_q  <= '0;
    end else if (zeroize) begin
      valid_q <= 1'b0;
      drbg_q  <= '0;
    end else if (accept) begin
      valid_q <= 1'b0;     // New request, old result no longer valid
    end else if (st_q == DONE) begin
      valid_q <= 1'b1;
      drbg_q  <= v_q;
    end
  end

  assign mix_cmd.start  = start_q;
  assign mix_cmd.absorb = absorb_q;
  assign mix_cmd.key    = k_q;
  assign mix_cmd.block  = blk_word;

  assign ready = ready_q;
  assign valid = valid_q;
  assign drbg  = drbg_q;

endmodule

`default_nettype wire

/* hdl/drbg_top.sv */
// DRBG top level, controller plus keyed mixing core
// init_cmd and next_cmd are strobes, taken only while ready is high
// valid and drbg are held levels, there is no back-pressure
// zeroize clears every register in one cycle

`default_nettype none

module drbg_top import drbg_pkg::*; (
  input  wire             clk,
  input  wire             reset_n,
  input  wire             zeroize,
  input  wire             init_cmd,
  input  wire             next_cmd,
  input  wire drbg_word_t entropy,
  input  wire drbg_word_t nonce,
  output logic            ready,
  output logic            valid,
  output drbg_word_t      drbg
);

  mix_cmd_t mix_cmd;   // Controller to core
  mix_rsp_t mix_rsp;   // Core to controller

  //------------------------------------------------------------
  // Sequencer
  //------------------------------------------------------------
  drbg_ctrl ctrl0 (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .init_cmd (init_cmd),
    .next_cmd (next_cmd),
    .entropy  (entropy),
    .nonce    (nonce),
    .mix_cmd  (mix_cmd),
    .mix_rsp  (mix_rsp),
    .ready    (ready),
    .valid    (valid),
    .drbg     (drbg)
  );

  // Keyed mixer in place of the HMAC
  keyed_mix_core mix0 (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .cmd     (mix_cmd),
    .rsp     (mix_rsp)
  );

endmodule

`default_nettype wire

/* sim/drbg_properties.sv */
// Concurrent checks on the DRBG top-level levels and the mixer strobes
// Bound into drbg_top, all checks are off while reset_n is low
// assert_fails holds the number of failed checks

`default_nettype none

module drbg_properties import drbg_pkg::*; (
  input wire              clk,
  input wire              reset_n,
  input wire              init_cmd,
  input wire              next_cmd,
  input wire              ready,
  input wire              valid,
  input wire mix_cmd_t    mix_cmd,
  input wire drbg_state_e st         // Controller state register
);

  int assert_fails = 0;

  //------------------------------------------------------------
  // Result level appears only when leaving DONE
  //------------------------------------------------------------
  a_valid_after_done: assert property (@(posedge clk) disable iff (!reset_n)
    (valid && ready && !$past(valid && ready)) |-> ($past(st) == DONE))
    else begin
      assert_fails++;
      $error("valid and ready rose together without a prior DONE");
    end

  // One mixer command per cycle at most
  a_one_mix_cmd: assert property (@(posedge clk) disable iff (!reset_n)
    !(mix_cmd.start && mix_cmd.absorb))
    else begin
      assert_fails++;
      $error("mixer start and absorb high in the same cycle");
    end

  // Accepted command takes the controller out of idle
  a_busy_after_cmd: assert property (@(posedge clk) disable iff (!reset_n)
    (ready && (init_cmd ^ next_cmd)) |=> !ready)
    else begin
      assert_fails++;
      $error("ready still high in the cycle after an accepted command");
    end

endmodule

bind drbg_top drbg_properties props0 (
  .clk      (clk),
  .reset_n  (reset_n),
  .init_cmd (init_cmd),
  .next_cmd (next_cmd),
  .ready    (ready),
  .valid    (valid),
  .mix_cmd  (mix_cmd),
  .st       (ctrl0.st_q)
);

`default_nettype wire

/* sim/drbg_tb.sv */
// Self-checking testbench for drbg_top
// Expected values come from a reference model of the mixer and the DRBG flow
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Random entropy and nonce from a fixed seed, so every run is the same

`default_nettype none

`include "drbg_consts.svh"

module drbg_tb import drbg_pkg::*; ();

  localparam int WAIT_MAX = 3000;   // Cycles before any wait gives up

  logic       clk;
  logic       reset_n;
  logic       zeroize;
  logic       init_cmd;
  logic       next_cmd;
  drbg_word_t entropy;
  drbg_word_t nonce;
  logic       ready;
  logic       valid;
  drbg_word_t drbg;

  drbg_word_t m_k;                  // Model K
  drbg_word_t m_v;                  // Model V, holds T after generate
  drbg_cnt_t  m_cnt;
  int         m_rejects;            // T values thrown out by the model
  drbg_word_t exp_q[$];             // Expected results, oldest first
  integer     seed;
  int         errors;
  int         tests;
  int         issued;
  int         checked;

  drbg_top dut0 (
    .clk (clk), .reset_n (reset_n), .zeroize (zeroize),
    .init_cmd (init_cmd), .next_cmd (next_cmd),
    .entropy (entropy), .nonce (nonce),
    .ready (ready), .valid (valid), .drbg (drbg)
  );

  always #2 clk = ~clk;             // Period 4

  //------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------
  // One block: XOR into the start value, then add key, rotate, XOR constant
  function automatic drbg_word_t mix_block(input drbg_word_t key, input drbg_word_t base,
                                           input drbg_word_t blk);
    drbg_word_t s;
    int         r;
    s = base ^ blk;
    for (r = 0; r < `MIX_ROUNDS; r++) begin
      s = s + key;
      s = (s << `MIX_ROT) | (s >> (`DRBG_W - `MIX_ROT));
      s = s ^ (`MIX_RC + r);
    end
    return s;
  endfunction

  // Seed message V, counter and marker, entropy, nonce
  function automatic drbg_word_t seed_tag(input drbg_word_t key, input drbg_word_t v,
                                          input drbg_cnt_t cnt, input logic [7:0] mark,
                                          input drbg_word_t ent, input drbg_word_t non);
    drbg_word_t t;
    t = mix_block(key, key, v);
    t = mix_block(key, t, {cnt, mark, {(`DRBG_W-16){1'b0}}});
    t = mix_block(key, t, ent);
    return mix_block(key, t, non);
  endfunction

  task automatic model_request(input logic is_init, input drbg_word_t ent,
                               input drbg_word_t non, output drbg_word_t t);
    int tries;
    if (is_init) begin
      m_k   = `DRBG_K_INIT;
      m_v   = `DRBG_V_INIT;
      m_cnt = '0;
    end else begin
      m_cnt = m_cnt + 8'd1;
    end
    m_k   = seed_tag(m_k, m_v, m_cnt, 8'h00, ent, non);
    m_v   = mix_block(m_k, m_k, m_v);
    m_cnt = m_cnt + 8'd1;
    m_k   = seed_tag(m_k, m_v, m_cnt, 8'h01, ent, non);
    m_v   = mix_block(m_k, m_k, m_v);
    t     = mix_block(m_k, m_k, m_v);
    m_v   = t;
    tries = 0;
    while ((t == '0 || t >= `DRBG_LIMIT) && tries < 64) begin
      m_k = mix_block(m_k, mix_block(m_k, m_k, m_v), '0);  // Key stays for the zero block
      m_v = mix_block(m_k, m_k, m_v);
      t   = mix_block(m_k, m_k, m_v);
      m_v = t;
      m_rejects++;
      tries++;
    end
  endtask

  function automatic drbg_word_t rand_word();
    drbg_word_t w;
    w[63:32] = $random(seed);
    w[31:0]  = $random(seed);
    return w;
  endfunction

  //------------------------------------------------------------
  // Run control and waits
  //------------------------------------------------------------
  task automatic finish_run();
    errors = errors + dut0.props0.assert_fails;
    $display("tests %0d, results checked %0d, errors %0d", tests, checked, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // Falling-edge wait for ready or valid to reach a level
  task automatic wait_flag(input bit sel_valid, input logic lvl);
    int n;
    n = 0;
    @(negedge clk);
    while ((sel_valid ? valid : ready) !== lvl) begin
      n++;
      if (n > WAIT_MAX) begin
        $display("Timeout, %s never reached %0b", sel_valid ? "valid" : "ready", lvl);
        errors++;
        finish_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic drive_cmd(input logic i, input logic x, input drbg_word_t e,
                           input drbg_word_t n);
    @(posedge clk);
    init_cmd <= i;
    next_cmd <= x;
    entropy  <= e;
    nonce    <= n;
    @(posedge clk);
    init_cmd <= 1'b0;
    next_cmd <= 1'b0;
  endtask

  // Advance the model, then hand the command to the DUT once it is idle
  task automatic issue_request(input logic is_init, input drbg_word_t e, input drbg_word_t n);
    drbg_word_t t;
    model_request(is_init, e, n, t);
    wait_flag(1'b0, 1'b1);
    drive_cmd(is_init, ~is_init, e, n);
    exp_q.push_back(t);
    issued++;
  endtask

  task automatic start_request(input logic is_init);
    drbg_word_t e;
    drbg_word_t n;
    e = rand_word();
    n = rand_word();
    issue_request(is_init, e, n);
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (checked < issued) begin
      @(posedge clk);
      n++;
      if (n > WAIT_MAX) begin
        $display("Timeout, result %0d was never compared", checked);
        errors++;
        finish_run();
      end
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
  endtask

  //------------------------------------------------------------
  // Compare process, one expected value per accepted request
  //------------------------------------------------------------
  initial begin : compare
    drbg_word_t exp;
    int         n;
    forever begin
      n = 0;
      @(negedge clk);
      while (exp_q.size() == 0) begin
        n++;
        if (n > 4 * WAIT_MAX) begin
          $display("Timeout, the compare process got no request");
          errors++;
          finish_run();
        end
        @(negedge clk);
      end
      wait_flag(1'b1, 1'b0);          // Old result cleared on accept
      wait_flag(1'b1, 1'b1);
      exp = exp_q.pop_front();
      if (drbg !== exp) begin
        $display("ERR drbg expected 0x%h actual 0x%h", exp, drbg);
        errors++;
      end
      if (drbg == '0 || drbg >= `DRBG_LIMIT) begin
        $display("ERR drbg out of range 0x%h limit 0x%h", drbg, `DRBG_LIMIT);
        errors++;
      end
      checked++;
    end
  end

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------
  initial begin : stimulus
    int         err0;
    int         k;
    drbg_word_t e;
    drbg_word_t n;
    drbg_word_t t;
    drbg_word_t sk;
    drbg_word_t sv;
    drbg_cnt_t  sc;
    clk = 1'b0;
    reset_n = 1'b0;
    zeroize = 1'b0;
    init_cmd = 1'b0;
    next_cmd = 1'b0;
    entropy = '0;
    nonce = '0;
    seed = 32'h3768_1f4b;
    errors = 0;
    tests = 0;
    issued = 0;
    checked = 0;
    m_k = '0;
    m_v = '0;
    m_cnt = '0;
    m_rejects = 0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    err0 = errors;                  // Reset state, then init
    wait_flag(1'b0, 1'b1);
    if (valid !== 1'b0) begin
      $display("ERR valid expected 0x0 actual 0x%h", valid);
      errors++;
    end
    if (drbg !== '0) begin
      $display("ERR drbg expected 0x0 actual 0x%h", drbg);
      errors++;
    end
    start_request(1'b1);
    wait_result();
    end_test("reset and init", err0);

    err0 = errors;
    for (k = 0; k < 12; k++) begin
      start_request(1'b0);
      wait_result();
    end
    end_test("twelve next requests", err0);

    err0 = errors;                  // Force a retry if none happened yet
    if (m_rejects == 0) begin
      sk = m_k;
      sv = m_v;
      sc = m_cnt;
      k = 0;
      while (m_rejects == 0 && k < 256) begin
        m_k = sk;
        m_v = sv;
        m_cnt = sc;
        e = rand_word();
        n = rand_word();
        model_request(1'b0, e, n, t);
        k++;
      end
      m_k = sk;                     // Replay the hit through the DUT
      m_v = sv;
      m_cnt = sc;
      m_rejects = 0;
      issue_request(1'b0, e, n);
      wait_result();
    end
    if (m_rejects == 0) begin
      $display("No T value was rejected, the retry path never ran");
      errors++;
    end
    end_test("range check and retry", err0);

    err0 = errors;                  // Strobes while busy must be dropped
    issue_request(1'b0, rand_word(), rand_word());
    for (k = 0; k < 6; k++) begin
      @(negedge clk);
      if (ready !== 1'b0) begin
        $display("ERR ready expected 0x0 actual 0x%h", ready);
        errors++;
      end
      @(posedge clk);
      init_cmd <= k[0];
      next_cmd <= ~k[0];
      entropy  <= rand_word();
      nonce    <= rand_word();
    end
    @(posedge clk);
    init_cmd <= 1'b0;
    next_cmd <= 1'b0;
    wait_result();
    wait_flag(1'b0, 1'b1);
    drive_cmd(1'b1, 1'b1, rand_word(), rand_word());  // Both at once
    repeat (3) begin
      @(negedge clk);
      if (ready !== 1'b1 || valid !== 1'b1) begin
        $display("ERR ready/valid expected 0x1/0x1 actual 0x%h/0x%h", ready, valid);
        errors++;
      end
    end
    start_request(1'b0);
    wait_result();
    end_test("ignored strobes", err0);

    err0 = errors;                  // Zeroize part way through a request
    wait_flag(1'b0, 1'b1);
    drive_cmd(1'b0, 1'b1, rand_word(), rand_word());
    repeat (20) @(posedge clk);
    @(negedge clk);
    if (ready !== 1'b0) begin
      $display("ERR ready expected 0x0 actual 0x%h", ready);
      errors++;
    end
    @(posedge clk);
    zeroize <= 1'b1;
    @(posedge clk);
    zeroize <= 1'b0;
    @(negedge clk);
    if (valid !== 1'b0) begin
      $display("ERR valid expected 0x0 actual 0x%h", valid);
      errors++;
    end
    if (drbg !== '0) begin
      $display("ERR drbg expected 0x0 actual 0x%h", drbg);
      errors++;
    end
    @(negedge clk);                 // Back in idle, request abandoned
    if (ready !== 1'b1) begin
      $display("ERR ready expected 0x1 actual 0x%h", ready);
      errors++;
    end
    if (valid !== 1'b0) begin
      $display("ERR valid expected 0x0 actual 0x%h", valid);
      errors++;
    end
    start_request(1'b1);
    wait_result();
    end_test("zeroize and init", err0);

    finish_run();
  end

endmodule

`default_nettype wire

/* drbg_mix.f */
+incdir+hdl
hdl/drbg_pkg.sv
hdl/keyed_mix_core.sv
hdl/drbg_ctrl.sv
hdl/drbg_top.sv
sim/drbg_properties.sv
sim/drbg_tb.sv
